/* hdl/itf_pkg.sv */
// Transfer unit shared definitions
// Beat layout, widths and the direction state used on both clock sides

package itf_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------

    // Payload width of one beat
    localparam int DATA_W = 32;

    // Default FIFO depth is 2**FIFO_AW_DEF entries
    localparam int FIFO_AW_DEF = 4;

    // ------------------------------------------------------------------------
    // Beat format
    // ------------------------------------------------------------------------

    // Flag marks a CCU instruction inbound, a command beat outbound
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              flag;
        logic              last;
    } beat_t;

    // Stored width of one beat inside the FIFOs
    localparam int BEAT_W = $bits(beat_t);

    // ------------------------------------------------------------------------
    // Direction control
    // ------------------------------------------------------------------------

    // One direction is active at a time on each side
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_IN,
        ST_OUT
    } xfer_state_e;

endpackage

/* hdl/itf_async_fifo.sv */
// Dual-clock first-word-fall-through FIFO
// Gray-coded pointers cross through two-flop synchronizers,
// so full and empty are conservative on each side

`timescale 1ns/1ns

module itf_async_fifo #(
    parameter int FIFO_AW = itf_pkg::FIFO_AW_DEF
) (
    input  logic           rst_n,
    input  logic           wr_clk_i,
    input  logic           rd_clk_i,
    input  logic           push_i,
    input  itf_pkg::beat_t wr_beat_i,
    input  logic           pop_i,
    output itf_pkg::beat_t rd_beat_o,
    output logic           full_o,
    output logic           empty_o
);
    import itf_pkg::*;

    localparam int DEPTH = 1 << FIFO_AW;

    logic [BEAT_W-1:0] mem_q [DEPTH];

    logic [FIFO_AW:0] wr_bin_q;
    logic [FIFO_AW:0] wr_gray_q;
    logic [FIFO_AW:0] rd_bin_q;
    logic [FIFO_AW:0] rd_gray_q;
    logic [FIFO_AW:0] rd_gray_s1_q;
    logic [FIFO_AW:0] rd_gray_s2_q;
    logic [FIFO_AW:0] wr_gray_s1_q;
    logic [FIFO_AW:0] wr_gray_s2_q;
    logic [FIFO_AW:0] rd_bin_wsync;
    logic [FIFO_AW:0] wr_bin_nxt;
    logic [FIFO_AW:0] rd_bin_nxt;
    logic             do_push;
    logic             do_pop;

    function automatic logic [FIFO_AW:0] gray2bin(input logic [FIFO_AW:0] g);
        logic [FIFO_AW:0] b;
        b[FIFO_AW] = g[FIFO_AW];
        for (int i = FIFO_AW - 1; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    // ------------------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------------------

    assign do_push    = push_i && !full_o;
    assign wr_bin_nxt = wr_bin_q + 1'b1;

    // Read pointer seen from the write clock, as binary
    assign rd_bin_wsync = gray2bin(rd_gray_s2_q);

    // Wrap bits differ and addresses match
    assign full_o = (wr_bin_q[FIFO_AW] != rd_bin_wsync[FIFO_AW]) &&
                    (wr_bin_q[FIFO_AW-1:0] == rd_bin_wsync[FIFO_AW-1:0]);

    always_ff @(posedge wr_clk_i or negedge rst_n) begin
        if (!rst_n) begin
            wr_bin_q     <= '0;
            wr_gray_q    <= '0;
            rd_gray_s1_q <= '0;
            rd_gray_s2_q <= '0;
        end else begin
            rd_gray_s1_q <= rd_gray_q;
            rd_gray_s2_q <= rd_gray_s1_q;
            if (do_push) begin
                wr_bin_q  <= wr_bin_nxt;
                wr_gray_q <= wr_bin_nxt ^ (wr_bin_nxt >> 1);
            end
        end
    end

    always_ff @(posedge wr_clk_i) begin
        if (do_push) begin
            mem_q[wr_bin_q[FIFO_AW-1:0]] <= wr_beat_i;
        end
    end

    // ------------------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------------------

    assign do_pop     = pop_i && !empty_o;
    assign rd_bin_nxt = rd_bin_q + 1'b1;
    assign empty_o    = (rd_gray_q == wr_gray_s2_q);

    // Head is visible without a pop
    assign rd_beat_o = beat_t'(mem_q[rd_bin_q[FIFO_AW-1:0]]);

    always_ff @(posedge rd_clk_i or negedge rst_n) begin
        if (!rst_n) begin
            rd_bin_q     <= '0;
            rd_gray_q    <= '0;
            wr_gray_s1_q <= '0;
            wr_gray_s2_q <= '0;
        end else begin
            wr_gray_s1_q <= wr_gray_q;
            wr_gray_s2_q <= wr_gray_s1_q;
            if (do_pop) begin
                rd_bin_q  <= rd_bin_nxt;
                rd_gray_q <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
            end
        end
    end

endmodule

/* hdl/itf_off_side.sv */
// Off-chip side direction controller
// Runs on OffClk and lets one packet move at a time, either from the
// off-chip master into the inbound FIFO or from the outbound FIFO out

`timescale 1ns/1ns

module itf_off_side (
    input  logic           OffClk,
    input  logic           rst_n,
    input  itf_pkg::beat_t off_in_beat_i,
    input  logic           off_in_vld_i,
    input  logic           off_out_rdy_i,
    input  logic           in_full_i,
    input  itf_pkg::beat_t out_beat_i,
    input  logic           out_empty_i,
    output logic           off_in_rdy_o,
    output itf_pkg::beat_t off_out_beat_o,
    output logic           off_out_vld_o,
    output logic           in_push_o,
    output itf_pkg::beat_t in_beat_o,
    output logic           out_pop_o
);
    import itf_pkg::*;

    xfer_state_e state_q;
    xfer_state_e state_d;
    logic        in_xfer;
    logic        out_xfer;

    // ------------------------------------------------------------------------
    // Handshakes
    // ------------------------------------------------------------------------

    assign off_in_rdy_o  = (state_q == ST_IN) && !in_full_i;
    assign off_out_vld_o = (state_q == ST_OUT) && !out_empty_i;

    assign in_xfer  = off_in_vld_i && off_in_rdy_o;
    assign out_xfer = off_out_vld_o && off_out_rdy_i;

    // Accepted inbound beats go straight into the FIFO
    assign in_push_o = in_xfer;
    assign in_beat_o = off_in_beat_i;

    // Outbound FIFO head drives the pins, popped on transfer
    assign off_out_beat_o = out_beat_i;
    assign out_pop_o      = out_xfer;

    // ------------------------------------------------------------------------
    // Direction FSM
    // ------------------------------------------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                // Off-chip master has priority
                if (off_in_vld_i) begin
                    state_d = ST_IN;
                end else if (!out_empty_i) begin
                    state_d = ST_OUT;
                end
            end
            ST_IN: begin
                if (in_xfer && off_in_beat_i.last) begin
                    state_d = ST_IDLE;
                end
            end
            ST_OUT: begin
                if (out_xfer && out_beat_i.last) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge OffClk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

/* hdl/itf_core_side.sv */
// Core side direction controller
// Routes inbound beats to the CCU or GIC stream by flag, and arbitrates
// outbound packets between the monitor and the GIC, one packet at a time

`timescale 1ns/1ns

module itf_core_side (
    input  logic           core_clk,
    input  logic           rst_n,
    input  itf_pkg::beat_t in_beat_i,
    input  logic           in_empty_i,
    input  logic           ccu_rdy_i,
    input  logic           gic_out_rdy_i,
    input  itf_pkg::beat_t gic_in_beat_i,
    input  logic           gic_in_vld_i,
    input  itf_pkg::beat_t mon_beat_i,
    input  logic           mon_vld_i,
    input  logic           out_full_i,
    output logic           in_pop_o,
    output itf_pkg::beat_t ccu_beat_o,
    output logic           ccu_vld_o,
    output itf_pkg::beat_t gic_out_beat_o,
    output logic           gic_out_vld_o,
    output logic           gic_in_rdy_o,
    output logic           mon_rdy_o,
    output logic           out_push_o,
    output itf_pkg::beat_t out_beat_o
);
    import itf_pkg::*;

    xfer_state_e state_q;
    xfer_state_e state_d;
    logic        src_mon_q;
    logic        src_mon_d;
    logic        in_head_vld;
    logic        out_room;
    beat_t       mon_fwd;

    // ------------------------------------------------------------------------
    // Inbound routing
    // ------------------------------------------------------------------------

    assign in_head_vld = (state_q == ST_IN) && !in_empty_i;

    // Flagged beats are CCU instructions
    assign ccu_vld_o     = in_head_vld && in_beat_i.flag;
    assign gic_out_vld_o = in_head_vld && !in_beat_i.flag;

    assign ccu_beat_o     = in_beat_i;
    assign gic_out_beat_o = in_beat_i;

    assign in_pop_o = (ccu_vld_o && ccu_rdy_i) || (gic_out_vld_o && gic_out_rdy_i);

    // ------------------------------------------------------------------------
    // Outbound source
    // ------------------------------------------------------------------------

    assign out_room     = (state_q == ST_OUT) && !out_full_i;
    assign mon_rdy_o    = out_room && src_mon_q;
    assign gic_in_rdy_o = out_room && !src_mon_q;

    // Monitor beats never carry the command flag
    always_comb begin
        mon_fwd      = mon_beat_i;
        mon_fwd.flag = 1'b0;
    end

    assign out_beat_o = src_mon_q ? mon_fwd : gic_in_beat_i;
    assign out_push_o = (mon_vld_i && mon_rdy_o) || (gic_in_vld_i && gic_in_rdy_o);

    // ------------------------------------------------------------------------
    // Direction FSM
    // ------------------------------------------------------------------------

    always_comb begin
        state_d   = state_q;
        src_mon_d = src_mon_q;
        case (state_q)
            ST_IDLE: begin
                if (!in_empty_i) begin
                    state_d = ST_IN;
                end else if (mon_vld_i || gic_in_vld_i) begin
                    // Source held until the packet's last beat
                    state_d   = ST_OUT;
                    src_mon_d = mon_vld_i;
                end
            end
            ST_IN: begin
                if (in_pop_o && in_beat_i.last) begin
                    state_d = ST_IDLE;
                end
            end
            ST_OUT: begin
                if (out_push_o && out_beat_o.last) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= ST_IDLE;
            src_mon_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            src_mon_q <= src_mon_d;
        end
    end

endmodule

/* hdl/itf_top.sv */
// Chip-boundary transfer unit
// Joins the OffClk and core_clk controllers through two async FIFOs

`timescale 1ns/1ns

module itf_top #(
    parameter int FIFO_AW = itf_pkg::FIFO_AW_DEF
) (
    input  logic           OffClk,
    input  logic           core_clk,
    input  logic           rst_n,
    // Off-chip side
    input  itf_pkg::beat_t off_in_beat_i,
    input  logic           off_in_vld_i,
    output logic           off_in_rdy_o,
    output itf_pkg::beat_t off_out_beat_o,
    output logic           off_out_vld_o,
    input  logic           off_out_rdy_i,
    // Core side
    output itf_pkg::beat_t ccu_beat_o,
    output logic           ccu_vld_o,
    input  logic           ccu_rdy_i,
    output itf_pkg::beat_t gic_out_beat_o,
    output logic           gic_out_vld_o,
    input  logic           gic_out_rdy_i,
    input  itf_pkg::beat_t gic_in_beat_i,
    input  logic           gic_in_vld_i,
    output logic           gic_in_rdy_o,
    input  itf_pkg::beat_t mon_beat_i,
    input  logic           mon_vld_i,
    output logic           mon_rdy_o
);
    import itf_pkg::*;

    // Inbound FIFO, OffClk to core_clk
    logic  in_push;
    beat_t in_wr_beat;
    logic  in_full;
    logic  in_pop;
    beat_t in_rd_beat;
    logic  in_empty;

    // Outbound FIFO, core_clk to OffClk
    logic  out_push;
    beat_t out_wr_beat;
    logic  out_full;
    logic  out_pop;
    beat_t out_rd_beat;
    logic  out_empty;

    itf_off_side u_off_side (
        .OffClk         (OffClk),
        .rst_n          (rst_n),
        .off_in_beat_i  (off_in_beat_i),
        .off_in_vld_i   (off_in_vld_i),
        .off_out_rdy_i  (off_out_rdy_i),
        .in_full_i      (in_full),
        .out_beat_i     (out_rd_beat),
        .out_empty_i    (out_empty),
        .off_in_rdy_o   (off_in_rdy_o),
        .off_out_beat_o (off_out_beat_o),
        .off_out_vld_o  (off_out_vld_o),
        .in_push_o      (in_push),
        .in_beat_o      (in_wr_beat),
        .out_pop_o      (out_pop)
    );

    itf_core_side u_core_side (
        .core_clk       (core_clk),
        .rst_n          (rst_n),
        .in_beat_i      (in_rd_beat),
        .in_empty_i     (in_empty),
        .ccu_rdy_i      (ccu_rdy_i),
        .gic_out_rdy_i  (gic_out_rdy_i),
        .gic_in_beat_i  (gic_in_beat_i),
        .gic_in_vld_i   (gic_in_vld_i),
        .mon_beat_i     (mon_beat_i),
        .mon_vld_i      (mon_vld_i),
        .out_full_i     (out_full),
        .in_pop_o       (in_pop),
        .ccu_beat_o     (ccu_beat_o),
        .ccu_vld_o      (ccu_vld_o),
        .gic_out_beat_o (gic_out_beat_o),
        .gic_out_vld_o  (gic_out_vld_o),
        .gic_in_rdy_o   (gic_in_rdy_o),
        .mon_rdy_o      (mon_rdy_o),
        .out_push_o     (out_push),
        .out_beat_o     (out_wr_beat)
    );

    itf_async_fifo #(
        .FIFO_AW (FIFO_AW)
    ) u_in_fifo (
        .rst_n     (rst_n),
        .wr_clk_i  (OffClk),
        .rd_clk_i  (core_clk),
        .push_i    (in_push),
        .wr_beat_i (in_wr_beat),
        .pop_i     (in_pop),
        .rd_beat_o (in_rd_beat),
        .full_o    (in_full),
        .empty_o   (in_empty)
    );

    itf_async_fifo #(
        .FIFO_AW (FIFO_AW)
    ) u_out_fifo (
        .rst_n     (rst_n),
        .wr_clk_i  (core_clk),
        .rd_clk_i  (OffClk),
        .push_i    (out_push),
        .wr_beat_i (out_wr_beat),
        .pop_i     (out_pop),
        .rd_beat_o (out_rd_beat),
        .full_o    (out_full),
        .empty_o   (out_empty)
    );

endmodule

/* testbench/itf_sva.sv */
// Off-chip handshake assertions
// Bound into the OffClk direction controller

`timescale 1ns/1ns

module itf_sva (
    input logic           OffClk,
    input logic           rst_n,
    input logic           in_rdy_i,
    input logic           in_full_i,
    input logic           out_vld_i,
    input logic           out_rdy_i,
    input itf_pkg::beat_t out_beat_i
);

    // Nothing handshakes while reset is held
    assert property (@(posedge OffClk) !rst_n |-> (!in_rdy_i && !out_vld_i))
        else $error("off-chip ready or valid high during reset");

    // A stalled outbound beat holds still
    assert property (@(posedge OffClk) disable iff (!rst_n)
        (out_vld_i && !out_rdy_i) |=> (out_vld_i && $stable(out_beat_i)))
        else $error("outbound beat changed while stalled");

    assert property (@(posedge OffClk) disable iff (!rst_n) in_full_i |-> !in_rdy_i)
        else $error("inbound ready high with the FIFO full");

endmodule

/* testbench/tb_itf.sv */
// Testbench for the chip-boundary transfer unit
// Random packets in both directions, checked against expected-beat queues

`timescale 1ns/1ns

module tb_itf;
    import itf_pkg::*;

    localparam int TIMEOUT  = 2000;
    localparam int RDY_LOW  = 0;
    localparam int RDY_HIGH = 1;
    localparam int RDY_RAND = 2;

    logic  OffClk;
    logic  core_clk;
    logic  rst_n;
    beat_t off_in_beat_i;
    logic  off_in_vld_i;
    logic  off_in_rdy_o;
    beat_t off_out_beat_o;
    logic  off_out_vld_o;
    logic  off_out_rdy_i;
    beat_t ccu_beat_o;
    logic  ccu_vld_o;
    logic  ccu_rdy_i;
    beat_t gic_out_beat_o;
    logic  gic_out_vld_o;
    logic  gic_out_rdy_i;
    beat_t gic_in_beat_i;
    logic  gic_in_vld_i;
    logic  gic_in_rdy_o;
    beat_t mon_beat_i;
    logic  mon_vld_i;
    logic  mon_rdy_o;

    integer seed = 32'h3d270ae4;
    int     core_rnd;
    int     off_rnd;
    int     core_rdy_mode = RDY_LOW;
    int     off_rdy_mode = RDY_LOW;
    int     errors = 0;
    int     checks = 0;
    int     tests = 0;
    int     err_mark = 0;
    string  test_name = "reset";

    // Beats waiting to be driven, and beats expected at each output
    beat_t off_tx[$];
    beat_t gic_tx[$];
    beat_t mon_tx[$];
    beat_t ccu_q[$];
    beat_t gicx_q[$];
    beat_t off_q[$];

    itf_top #(
        .FIFO_AW (FIFO_AW_DEF)
    ) uut (.*);

    bind itf_off_side itf_sva u_sva (
        .OffClk     (OffClk),
        .rst_n      (rst_n),
        .in_rdy_i   (off_in_rdy_o),
        .in_full_i  (in_full_i),
        .out_vld_i  (off_out_vld_o),
        .out_rdy_i  (off_out_rdy_i),
        .out_beat_i (off_out_beat_o)
    );

    always #10 OffClk = ~OffClk;
    always #7 core_clk = ~core_clk;

    // ------------------------------------------------------------------------
    // Downstream readies
    // ------------------------------------------------------------------------

    always @(posedge core_clk) begin
        core_rnd = $random(seed);
        ccu_rdy_i     <= (core_rdy_mode == RDY_HIGH) || (core_rdy_mode == RDY_RAND && core_rnd[0]);
        gic_out_rdy_i <= (core_rdy_mode == RDY_HIGH) || (core_rdy_mode == RDY_RAND && core_rnd[1]);
    end

    always @(posedge OffClk) begin
        off_rnd = $random(seed);
        off_out_rdy_i <= (off_rdy_mode == RDY_HIGH) || (off_rdy_mode == RDY_RAND && off_rnd[0]);
    end

    // ------------------------------------------------------------------------
    // Checking
    // ------------------------------------------------------------------------

    task automatic check(input string name, input logic [BEAT_W-1:0] exp,
                         input logic [BEAT_W-1:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic stalled(input string stream);
        errors++;
        $display("%s stream stalled in %s", stream, test_name);
    endtask

    task automatic unexpected(input string stream);
        errors++;
        $display("%s stream delivered a beat that was not expected in %s", stream, test_name);
    endtask

    // Handshakes sampled mid-cycle for the transfer on the next edge
    always @(negedge core_clk) begin
        if (rst_n && ccu_vld_o && ccu_rdy_i) begin
            if (ccu_q.size() == 0) unexpected("CCU");
            else check(test_name, ccu_q.pop_front(), ccu_beat_o);
        end
        if (rst_n && gic_out_vld_o && gic_out_rdy_i) begin
            if (gicx_q.size() == 0) unexpected("GIC outbound");
            else check(test_name, gicx_q.pop_front(), gic_out_beat_o);
        end
    end

    always @(negedge OffClk) begin
        if (rst_n && off_out_vld_o && off_out_rdy_i) begin
            if (off_q.size() == 0) unexpected("off-chip outbound");
            else check(test_name, off_q.pop_front(), off_out_beat_o);
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    function automatic beat_t rand_beat(input logic last);
        beat_t b;
        int    r;
        r      = $random(seed);
        b.data = $random(seed);
        b.flag = r[0];
        b.last = last;
        return b;
    endfunction

    function automatic int rand_len();
        int r;
        r = $random(seed);
        return 1 + int'(r[1:0]);
    endfunction

    // Flagged inbound beats belong to the CCU
    task automatic make_inbound(input int n_pkts);
        beat_t b;
        int    len;
        repeat (n_pkts) begin
            len = rand_len();
            for (int i = 0; i < len; i++) begin
                b = rand_beat(i == len - 1);
                off_tx.push_back(b);
                if (b.flag) ccu_q.push_back(b);
                else gicx_q.push_back(b);
            end
        end
    endtask

    task automatic make_gic(input int n_pkts);
        beat_t b;
        int    len;
        repeat (n_pkts) begin
            len = rand_len();
            for (int i = 0; i < len; i++) begin
                b = rand_beat(i == len - 1);
                gic_tx.push_back(b);
                off_q.push_back(b);
            end
        end
    endtask

    // Monitor beats leave the chip with the command flag cleared
    task automatic make_mon(input int n_pkts);
        beat_t b;
        int    len;
        repeat (n_pkts) begin
            len = rand_len();
            for (int i = 0; i < len; i++) begin
                b = rand_beat(i == len - 1);
                // Driven flag always set
                b.flag = 1'b1;
                mon_tx.push_back(b);
                b.flag = 1'b0;
                off_q.push_back(b);
            end
        end
    endtask

    // Each send task starts just after a rising edge of its clock
    task automatic send_off();
        int cnt;
        while (off_tx.size() > 0) begin
            off_in_beat_i <= off_tx.pop_front();
            off_in_vld_i  <= 1'b1;
            cnt = 0;
            @(negedge OffClk);
            while (!off_in_rdy_o && cnt < TIMEOUT) begin
                @(negedge OffClk);
                cnt++;
            end
            if (!off_in_rdy_o) stalled("off-chip inbound");
            @(posedge OffClk);
        end
        off_in_vld_i <= 1'b0;
    endtask

    task automatic send_gic();
        int cnt;
        while (gic_tx.size() > 0) begin
            gic_in_beat_i <= gic_tx.pop_front();
            gic_in_vld_i  <= 1'b1;
            cnt = 0;
            @(negedge core_clk);
            while (!gic_in_rdy_o && cnt < TIMEOUT) begin
                @(negedge core_clk);
                cnt++;
            end
            if (!gic_in_rdy_o) stalled("GIC inbound");
            @(posedge core_clk);
        end
        gic_in_vld_i <= 1'b0;
    endtask

    task automatic send_mon();
        int cnt;
        while (mon_tx.size() > 0) begin
            mon_beat_i <= mon_tx.pop_front();
            mon_vld_i  <= 1'b1;
            cnt = 0;
            @(negedge core_clk);
            while (!mon_rdy_o && cnt < TIMEOUT) begin
                @(negedge core_clk);
                cnt++;
            end
            if (!mon_rdy_o) stalled("monitor");
            @(posedge core_clk);
        end
        mon_vld_i <= 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = errors;
        tests++;
    endtask

    // Wait until every expected beat has arrived, then report the test
    task automatic end_test();
        int cnt;
        cnt = 0;
        while (ccu_q.size() + gicx_q.size() + off_q.size() != 0 && cnt < TIMEOUT) begin
            @(posedge OffClk);
            cnt++;
        end
        if (ccu_q.size() != 0) stalled("CCU");
        if (gicx_q.size() != 0) stalled("GIC outbound");
        if (off_q.size() != 0) stalled("off-chip outbound");
        ccu_q.delete();
        gicx_q.delete();
        off_q.delete();
        // Room for a stray extra beat to show up
        repeat (4) @(posedge OffClk);
        // Next test is set up away from the ready updates
        @(negedge OffClk);
        $display("%s finished with %0d errors", test_name, errors - err_mark);
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------

    initial begin
        OffClk        = 1'b0;
        core_clk      = 1'b0;
        rst_n         = 1'b0;
        off_in_beat_i = '0;
        off_in_vld_i  = 1'b0;
        off_out_rdy_i = 1'b0;
        ccu_rdy_i     = 1'b0;
        gic_out_rdy_i = 1'b0;
        gic_in_beat_i = '0;
        gic_in_vld_i  = 1'b0;
        mon_beat_i    = '0;
        mon_vld_i     = 1'b0;
        repeat (8) @(posedge OffClk);
        rst_n <= 1'b1;

        start_test("reset_outputs");
        @(negedge OffClk);
        check(test_name, '0, BEAT_W'({off_in_rdy_o, off_out_vld_o, ccu_vld_o,
                                      gic_out_vld_o, gic_in_rdy_o, mon_rdy_o}));
        end_test();

        start_test("inbound_routing");
        core_rdy_mode = RDY_RAND;
        make_inbound(12);
        @(posedge OffClk);
        send_off();
        end_test();

        start_test("outbound_gic");
        off_rdy_mode = RDY_RAND;
        make_gic(10);
        @(posedge core_clk);
        send_gic();
        end_test();

        start_test("monitor_priority");
        off_rdy_mode = RDY_HIGH;
        make_mon(1);
        make_gic(1);
        @(posedge core_clk);
        fork
            send_mon();
            send_gic();
        join
        end_test();

        // More beats than the outbound FIFO holds
        start_test("outbound_backpressure");
        off_rdy_mode = RDY_LOW;
        while (gic_tx.size() <= 20) make_gic(1);
        @(posedge core_clk);
        fork
            send_gic();
            begin
                repeat (60) @(posedge OffClk);
                @(negedge OffClk);
                off_rdy_mode = RDY_HIGH;
            end
        join
        end_test();

        start_test("inbound_backpressure");
        core_rdy_mode = RDY_LOW;
        while (off_tx.size() <= 24) make_inbound(1);
        @(posedge OffClk);
        fork
            send_off();
            begin
                repeat (100) @(posedge OffClk);
                @(negedge OffClk);
                // Valid still held while the full FIFO drops ready
                check(test_name, BEAT_W'(2'b10), BEAT_W'({off_in_vld_i, off_in_rdy_o}));
                core_rdy_mode = RDY_RAND;
            end
        join
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* list.f */
hdl/itf_pkg.sv
hdl/itf_async_fifo.sv
hdl/itf_off_side.sv
hdl/itf_core_side.sv
hdl/itf_top.sv
testbench/itf_sva.sv
testbench/tb_itf.sv

/* run.sh */
#!/bin/sh
# Build and run the transfer unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_itf -f list.f -o sim_itf
./obj_dir/sim_itf | tee sim.log

grep -qx "test passed" sim.log
